//--- hw/fifo_demo_pkg.sv
// Shared widths, types, pattern table and display signs for the FIFO demo; imported by each block

package fifo_demo_pkg;

    //------------------------------------------------------------
    // sizes

    localparam fifo_width    = 4;
    localparam fifo_depth    = 5;
    localparam w_digit       = 4;

    // each digit stays lit for 2 ** scan_div_bits clock cycles
    localparam scan_div_bits = 4;

    //------------------------------------------------------------
    // vector types

    typedef logic [fifo_width - 1:0] nibble_t;
    typedef logic [2:0]              ptr_t;
    typedef logic [2:0]              count_t;

    // segments abcdefgh, a in bit 7, active high
    typedef logic [7:0]              seg_t;

    // one-hot digit select, bit 0 is the rightmost digit
    typedef logic [w_digit - 1:0]    digit_t;

    //------------------------------------------------------------
    // FIFO status, exported with the pointers for debugging

    typedef struct packed
    {
        logic empty;
        logic full;
        ptr_t wr_ptr;
        ptr_t rd_ptr;
    } fifo_status_t;

    // display scan order, rightmost digit first
    typedef enum logic [1:0]
    {
        scan_read,
        scan_rd_ptr,
        scan_wr_ptr,
        scan_write
    } scan_state_e;

    //------------------------------------------------------------
    // constants

    localparam nibble_t pattern_table [0:15] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    // bottom bar for empty, top bar for full
    localparam seg_t sign_empty = 8'b0001_0000;
    localparam seg_t sign_full  = 8'b1000_0000;

endpackage

//--- hw/pattern_source.sv
// Producer for the FIFO demo; pushes table values while the push key is held and the FIFO is not full

`timescale 1ns/10ps

module pattern_source
    import fifo_demo_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,

    // push key, active high
    input  logic    push_key,

    // from the buffer status
    input  logic    full,

    output logic    push,
    output nibble_t write_data
);

    //------------------------------------------------------------
    // push gating

    // never push into a full FIFO, even when a pop happens
    // in the same cycle
    assign push = push_key & ~full;

    //------------------------------------------------------------
    // pattern index

    logic [3:0] index;

    // wraps after the last of the sixteen table entries
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            index <= '0;
        end
        else if (push)
        begin
            index <= index + 1'b1;
        end
    end

    //------------------------------------------------------------
    // table lookup

    // the next value to push is visible before the push edge
    assign write_data = pattern_table[index];

endmodule

//--- hw/ff_fifo.sv
// Flip-flop FIFO with an occupancy counter and show-ahead read; push and pop are trusted strobes

`timescale 1ns/10ps

module ff_fifo
    import fifo_demo_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,

    input  logic         push,
    input  logic         pop,

    input  nibble_t      write_data,
    output nibble_t      read_data,

    // registered flags plus both pointers
    output fifo_status_t status
);

    //------------------------------------------------------------
    // storage

    nibble_t data [0:fifo_depth - 1];

    // status holds the live pointers, no separate copies
    ptr_t    wr_ptr;
    ptr_t    rd_ptr;
    count_t  cnt;
    count_t  cnt_next;

    assign wr_ptr = status.wr_ptr;
    assign rd_ptr = status.rd_ptr;

    // depth is not a power of two so the pointer wraps explicitly
    function automatic ptr_t ptr_inc(input ptr_t p);
        if (p == ptr_t'(fifo_depth - 1))
            return '0;
        else
            return p + 1'b1;
    endfunction

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            data[wr_ptr] <= write_data;
        end
    end

    // show-ahead, the head entry is always on read_data
    assign read_data = data[rd_ptr];

    //------------------------------------------------------------
    // occupancy

    always_comb
    begin
        cnt_next = cnt;

        if (push & ~pop)
            cnt_next = cnt + 1'b1;
        else if (pop & ~push)
            cnt_next = cnt - 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cnt <= '0;
        end
        else
        begin
            cnt <= cnt_next;
        end
    end

    //------------------------------------------------------------
    // pointers and flags

    // flags come from the next count so they line up with cnt
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            status.empty  <= 1'b1;
            status.full   <= 1'b0;
            status.wr_ptr <= '0;
            status.rd_ptr <= '0;
        end
        else
        begin
            status.empty <= (cnt_next == '0);
            status.full  <= (cnt_next == count_t'(fifo_depth));

            if (push)
                status.wr_ptr <= ptr_inc(wr_ptr);

            if (pop)
                status.rd_ptr <= ptr_inc(rd_ptr);
        end
    end

endmodule

//--- hw/fifo_status_display.sv
// Consumer for the FIFO demo; pops on the pop key and scans FIFO data and pointers onto four digits

`timescale 1ns/10ps

module fifo_status_display
    import fifo_demo_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,

    // pop key, active high
    input  logic         pop_key,

    input  fifo_status_t status,
    input  nibble_t      read_data,
    input  nibble_t      write_data,

    output logic         pop,

    output seg_t         abcdefgh,
    output digit_t       digit
);

    //------------------------------------------------------------
    // pop gating

    assign pop = pop_key & ~status.empty;

    //------------------------------------------------------------
    // scan divider and FSM

    logic [scan_div_bits - 1:0] scan_cnt;
    scan_state_e                state;
    scan_state_e                state_next;

    always_comb
    begin
        case (state)
            scan_read:   state_next = scan_rd_ptr;
            scan_rd_ptr: state_next = scan_wr_ptr;
            scan_wr_ptr: state_next = scan_write;
            default:     state_next = scan_read;
        endcase
    end

    // state moves on the last cycle of each divider period
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            scan_cnt <= '0;
            state    <= scan_read;
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;

            if (scan_cnt == '1)
                state <= state_next;
        end
    end

    //------------------------------------------------------------
    // digit select and value

    nibble_t hex;

    always_comb
    begin
        case (state)
            scan_read:
            begin
                digit = 4'b0001;
                hex   = read_data;
            end
            scan_rd_ptr:
            begin
                digit = 4'b0010;
                hex   = nibble_t'(status.rd_ptr);
            end
            scan_wr_ptr:
            begin
                digit = 4'b0100;
                hex   = nibble_t'(status.wr_ptr);
            end
            default:
            begin
                digit = 4'b1000;
                hex   = write_data;
            end
        endcase
    end

    //------------------------------------------------------------
    // segment decode

    seg_t hex_seg;

    always_comb
    begin
        case (hex)
            4'h0:    hex_seg = 8'b1111_1100;
            4'h1:    hex_seg = 8'b0110_0000;
            4'h2:    hex_seg = 8'b1101_1010;
            4'h3:    hex_seg = 8'b1111_0010;
            4'h4:    hex_seg = 8'b0110_0110;
            4'h5:    hex_seg = 8'b1011_0110;
            4'h6:    hex_seg = 8'b1011_1110;
            4'h7:    hex_seg = 8'b1110_0000;
            4'h8:    hex_seg = 8'b1111_1110;
            4'h9:    hex_seg = 8'b1111_0110;
            4'ha:    hex_seg = 8'b1110_1110;
            4'hb:    hex_seg = 8'b0011_1110;
            4'hc:    hex_seg = 8'b1001_1100;
            4'hd:    hex_seg = 8'b0111_1010;
            4'he:    hex_seg = 8'b1001_1110;
            default: hex_seg = 8'b1000_1110;
        endcase
    end

    // empty hides the stale head entry, full hides the blocked value
    always_comb
    begin
        if (state == scan_read && status.empty)
            abcdefgh = sign_empty;
        else if (state == scan_write && status.full)
            abcdefgh = sign_full;
        else
            abcdefgh = hex_seg;
    end

endmodule

//--- hw/fifo_demo_top.sv
// Board top level of the FIFO demo; wires producer, FIFO and display to keys and segment pins

`timescale 1ns/10ps

module fifo_demo_top
    import fifo_demo_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    // bit 1 pushes, bit 0 pops
    input  logic [1:0] key,

    // dynamic seven-segment display
    output seg_t       abcdefgh,
    output digit_t     digit
);

    //------------------------------------------------------------
    // block interconnect

    logic         push;
    logic         pop;
    nibble_t      write_data;
    nibble_t      read_data;
    fifo_status_t status;

    //------------------------------------------------------------
    // producer

    pattern_source u_pattern_source
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .push_key   (key[1]),
        .full       (status.full),
        .push       (push),
        .write_data (write_data)
    );

    //------------------------------------------------------------
    // buffer

    ff_fifo u_ff_fifo
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .push       (push),
        .pop        (pop),
        .write_data (write_data),
        .read_data  (read_data),
        .status     (status)
    );

    //------------------------------------------------------------
    // consumer

    fifo_status_display u_fifo_status_display
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .pop_key    (key[0]),
        .status     (status),
        .read_data  (read_data),
        .write_data (write_data),
        .pop        (pop),
        .abcdefgh   (abcdefgh),
        .digit      (digit)
    );

endmodule

//--- verification/tb_fifo_demo.sv
// Directed testbench for the FIFO demo top level; drives the keys and checks every scanned digit

`timescale 1ns/10ps

module tb_fifo_demo
    import fifo_demo_pkg::*;
();

    //------------------------------------------------------------
    // DUT and clock

    logic   clk;
    logic   arst_n;
    logic   [1:0] key;
    seg_t   abcdefgh;
    digit_t digit;

    fifo_demo_top u_fifo_demo_top
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .key      (key),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    always #20 clk = ~clk;

    // about 60 key steps plus one display scan of at most 64 cycles each, with margin
    localparam int max_cycles = 20000;

    int cycles;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > max_cycles)
        begin
            $display("timeout after %0d cycles, the display scan never completed", cycles);
            $display("TESTBENCH FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    //------------------------------------------------------------
    // reference model

    localparam seg_t seg_a = 8'h80;
    localparam seg_t seg_b = 8'h40;
    localparam seg_t seg_c = 8'h20;
    localparam seg_t seg_d = 8'h10;
    localparam seg_t seg_e = 8'h08;
    localparam seg_t seg_f = 8'h04;
    localparam seg_t seg_g = 8'h02;

    localparam nibble_t pattern_values [0:15] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    nibble_t     exp_q [$];
    ptr_t        m_wr;
    ptr_t        m_rd;
    logic [3:0]  m_index;
    int          total_pushes;
    logic [31:0] rng;

    function automatic ptr_t next_ptr(input ptr_t p);
        return (p == 3'd4) ? 3'd0 : p + 3'd1;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic seg_t seg_of_hex(input nibble_t h);
        case (h)
            4'h0:    return seg_a | seg_b | seg_c | seg_d | seg_e | seg_f;
            4'h1:    return seg_b | seg_c;
            4'h2:    return seg_a | seg_b | seg_d | seg_e | seg_g;
            4'h3:    return seg_a | seg_b | seg_c | seg_d | seg_g;
            4'h4:    return seg_b | seg_c | seg_f | seg_g;
            4'h5:    return seg_a | seg_c | seg_d | seg_f | seg_g;
            4'h6:    return seg_a | seg_c | seg_d | seg_e | seg_f | seg_g;
            4'h7:    return seg_a | seg_b | seg_c;
            4'h8:    return seg_a | seg_b | seg_c | seg_d | seg_e | seg_f | seg_g;
            4'h9:    return seg_a | seg_b | seg_c | seg_d | seg_f | seg_g;
            4'ha:    return seg_a | seg_b | seg_c | seg_e | seg_f | seg_g;
            4'hb:    return seg_c | seg_d | seg_e | seg_f | seg_g;
            4'hc:    return seg_a | seg_d | seg_e | seg_f;
            4'hd:    return seg_b | seg_c | seg_d | seg_e | seg_g;
            4'he:    return seg_a | seg_d | seg_e | seg_f | seg_g;
            default: return seg_a | seg_e | seg_f | seg_g;
        endcase
    endfunction

    // position 0 is the read digit, 3 the write digit
    function automatic seg_t expected_segments(input int pos);
        case (pos)
            0:       return (exp_q.size() == 0) ? seg_d : seg_of_hex(exp_q[0]);
            1:       return seg_of_hex({1'b0, m_rd});
            2:       return seg_of_hex({1'b0, m_wr});
            default: return (exp_q.size() == fifo_depth) ? seg_a
                                                         : seg_of_hex(pattern_values[m_index]);
        endcase
    endfunction

    // one clock edge worth of key effect, with the same full and empty gating
    task automatic update_model(input logic pk, input logic ppk);
        logic do_push;
        logic do_pop;
        do_push = pk && (exp_q.size() < fifo_depth);
        do_pop  = ppk && (exp_q.size() > 0);
        if (do_pop)
        begin
            void'(exp_q.pop_front());
            m_rd = next_ptr(m_rd);
        end
        if (do_push)
        begin
            exp_q.push_back(pattern_values[m_index]);
            m_wr = next_ptr(m_wr);
            m_index = m_index + 4'd1;
            total_pushes = total_pushes + 1;
        end
    endtask

    //------------------------------------------------------------
    // compare and drive helpers

    task automatic compare_digit(input string name, input digit_t got, input digit_t exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "digit select check failed");
        end
    endtask

    task automatic compare_seg(input string name, input seg_t got, input seg_t exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "segment check failed");
        end
    endtask

    // starts and ends on a falling edge
    task automatic apply_keys(input logic pk, input logic ppk, input int len);
        key = {pk, ppk};
        for (int n = 0; n < len; n++)
        begin
            update_model(pk, ppk);
            @(negedge clk);
        end
        key = 2'b00;
    endtask

    // syncs on the read digit, then follows the scan through every digit change
    task automatic check_display();
        digit_t sel;
        digit_t prev;
        while (digit !== 4'b0001)
            @(negedge clk);
        for (int i = 0; i < w_digit; i++)
        begin
            sel = digit_t'(4'b0001 << i);
            if (i > 0)
            begin
                prev = digit;
                while (digit === prev)
                    @(negedge clk);
            end
            compare_digit("digit", digit, sel);
            compare_seg($sformatf("abcdefgh[digit %0d]", i), abcdefgh, expected_segments(i));
        end
    endtask

    //------------------------------------------------------------
    // directed tests

    task automatic reset_state();
        compare_digit("digit", digit, 4'b0001);
        check_display();
    endtask

    task automatic single_push();
        apply_keys(1'b1, 1'b0, 1);
        check_display();
    endtask

    // eight push cycles, only the free entries are taken
    task automatic fill_until_full();
        apply_keys(1'b1, 1'b0, 8);
        check_display();
    endtask

    task automatic drain_in_order();
        while (exp_q.size() > 0)
        begin
            apply_keys(1'b0, 1'b1, 1);
            check_display();
        end
        apply_keys(1'b0, 1'b1, 1);
        apply_keys(1'b0, 1'b1, 2);
        check_display();
    endtask

    task automatic random_mix();
        int len;
        for (int s = 0; s < 40; s++)
        begin
            rng = xorshift32(rng);
            len = int'(rng[3:2]) + 1;
            apply_keys(rng[1], rng[0], len);
            check_display();
        end
        if (total_pushes <= 16)
        begin
            $display("the pattern index never wrapped, only %0d pushes", total_pushes);
            $display("TESTBENCH FAILED");
            $fatal(1, "coverage of the index wrap missing");
        end
    endtask

    //------------------------------------------------------------
    // main sequence

    initial
    begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        key          = 2'b00;
        cycles       = 0;
        m_wr         = '0;
        m_rd         = '0;
        m_index      = '0;
        total_pushes = 0;
        rng          = 32'd86;

        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        reset_state();
        single_push();
        fill_until_full();
        drain_in_order();
        random_mix();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- all.f
hw/fifo_demo_pkg.sv
hw/pattern_source.sv
hw/ff_fifo.sv
hw/fifo_status_display.sv
hw/fifo_demo_top.sv
verification/tb_fifo_demo.sv

//--- Makefile
.PHONY: all run lint clean

all: run

run: obj_dir/Vtb_fifo_demo
	./obj_dir/Vtb_fifo_demo

obj_dir/Vtb_fifo_demo: all.f hw/*.sv verification/*.sv
	verilator --binary --timing --top-module tb_fifo_demo -f all.f -o Vtb_fifo_demo

lint:
	verilator --lint-only -Wall --top-module fifo_demo_top \
		hw/fifo_demo_pkg.sv hw/pattern_source.sv hw/ff_fifo.sv \
		hw/fifo_status_display.sv hw/fifo_demo_top.sv

clean:
	rm -rf obj_dir
